//--- source/idu_pkg.sv
// MIPS32 subset only; no mult/div, hi/lo, cp0, syscall/break or byte memory ops
`default_nettype none

package idu_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    localparam reg_addr_t REG_LINK = 5'd31;  // jal / bgezal write-back
    localparam word_t     PC_STEP  = 32'd4;

    // primary opcodes
    localparam logic [5:0] OP_SPECIAL = 6'b000000;
    localparam logic [5:0] OP_REGIMM  = 6'b000001;
    localparam logic [5:0] OP_J       = 6'b000010;
    localparam logic [5:0] OP_JAL     = 6'b000011;
    localparam logic [5:0] OP_BEQ     = 6'b000100;
    localparam logic [5:0] OP_BNE     = 6'b000101;
    localparam logic [5:0] OP_BLEZ    = 6'b000110;
    localparam logic [5:0] OP_BGTZ    = 6'b000111;
    localparam logic [5:0] OP_ADDI    = 6'b001000;
    localparam logic [5:0] OP_ADDIU   = 6'b001001;
    localparam logic [5:0] OP_SLTI    = 6'b001010;
    localparam logic [5:0] OP_SLTIU   = 6'b001011;
    localparam logic [5:0] OP_ANDI    = 6'b001100;
    localparam logic [5:0] OP_ORI     = 6'b001101;
    localparam logic [5:0] OP_XORI    = 6'b001110;
    localparam logic [5:0] OP_LUI     = 6'b001111;
    localparam logic [5:0] OP_LW      = 6'b100011;
    localparam logic [5:0] OP_SW      = 6'b101011;

    // SPECIAL funct codes
    localparam logic [5:0] F_SLL  = 6'b000000;
    localparam logic [5:0] F_SRL  = 6'b000010;
    localparam logic [5:0] F_SRA  = 6'b000011;
    localparam logic [5:0] F_JR   = 6'b001000;
    localparam logic [5:0] F_JALR = 6'b001001;
    localparam logic [5:0] F_ADD  = 6'b100000;
    localparam logic [5:0] F_ADDU = 6'b100001;
    localparam logic [5:0] F_SUB  = 6'b100010;
    localparam logic [5:0] F_SUBU = 6'b100011;
    localparam logic [5:0] F_AND  = 6'b100100;
    localparam logic [5:0] F_OR   = 6'b100101;
    localparam logic [5:0] F_XOR  = 6'b100110;
    localparam logic [5:0] F_SLT  = 6'b101010;

    // REGIMM rt codes
    localparam reg_addr_t RT_BLTZ   = 5'b00000;
    localparam reg_addr_t RT_BGEZAL = 5'b10001;

    typedef struct packed {
        logic [5:0] opcode;
        reg_addr_t  rs;
        reg_addr_t  rt;
        reg_addr_t  rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } r_fields_t;

    typedef struct packed {
        logic [5:0]  opcode;
        reg_addr_t   rs;
        reg_addr_t   rt;
        logic [15:0] imm;  // also branch offset
    } i_fields_t;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [25:0] index;
    } j_fields_t;

    typedef union packed {
        r_fields_t r_fields;
        i_fields_t i_fields;
        j_fields_t j_fields;
    } mips_inst_u;

    typedef enum logic [5:0] {
        ALU_NOP, ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI,
        ALU_LW, ALU_SW,
        ALU_BEQ, ALU_BNE, ALU_BLEZ, ALU_BGTZ, ALU_BLTZ, ALU_BGEZAL,
        ALU_J, ALU_JAL, ALU_JR, ALU_JALR,
        ALU_UNKNOWN
    } alu_op_e;

    typedef enum logic [2:0] {
        OPA_ZERO, OPA_RS, OPA_SHAMT, OPA_LUI, OPA_PC
    } opa_sel_e;

    typedef enum logic [2:0] {
        OPB_ZERO, OPB_RT, OPB_IMM_S, OPB_IMM_Z, OPB_STEP
    } opb_sel_e;

    typedef struct packed {
        logic       valid;
        word_t      pc;
        mips_inst_u inst;
    } fetch_t;

    typedef struct packed {
        alu_op_e   alu_op;
        opa_sel_e  opa_sel;
        opb_sel_e  opb_sel;
        logic      mem_rd;
        logic      mem_wr;
        logic      reg_wr;
        reg_addr_t reg_dst;
    } ctrl_t;

    typedef struct packed {
        logic  taken;
        word_t target;
    } jump_t;

endpackage

`default_nettype wire

//--- source/fetch_latch.sv
// one instruction per clock with no stall input; reset leaves an invalid zero entry
`timescale 1ns/1ps
`default_nettype none

module fetch_latch
    import idu_pkg::*;
(
    input  wire        clk,
    input  wire        rst,
    input  word_t      pc_i,
    input  word_t      inst_i,
    output fetch_t     stage_o,
    output reg_addr_t  rs_addr_o,
    output reg_addr_t  rt_addr_o
);

    fetch_t stage_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            stage_q <= '0;  // bubble
        end else begin
            stage_q.valid <= 1'b1;
            stage_q.pc    <= pc_i;
            stage_q.inst  <= inst_i;
        end
    end

    assign stage_o = stage_q;

    // register file is read from the held word, data returns in the same cycle
    assign rs_addr_o = stage_q.inst.r_fields.rs;
    assign rt_addr_o = stage_q.inst.r_fields.rt;

endmodule

`default_nettype wire

//--- source/inst_decoder.sv
// decodes only the kept MIPS subset; reserved zero fields must be zero or the word is unknown
`timescale 1ns/1ps
`default_nettype none

module inst_decoder
    import idu_pkg::*;
(
    input  fetch_t stage_i,
    output ctrl_t  ctrl_o
);

    mips_inst_u inst;
    reg_addr_t  rd;
    reg_addr_t  rt;
    logic       shamt_zero;
    logic       rs_zero;
    logic       rt_zero;
    logic       rd_zero;

    assign inst       = stage_i.inst;
    assign rd         = inst.r_fields.rd;
    assign rt         = inst.i_fields.rt;
    assign shamt_zero = (inst.r_fields.shamt == 5'd0);
    assign rs_zero    = (inst.i_fields.rs == 5'd0);
    assign rt_zero    = (rt == 5'd0);
    assign rd_zero    = (rd == 5'd0);

    function automatic ctrl_t make_ctrl(
        input alu_op_e   op,
        input opa_sel_e  opa,
        input opb_sel_e  opb,
        input logic      wr,
        input reg_addr_t dst
    );
        ctrl_t c;
        c.alu_op  = op;
        c.opa_sel = opa;
        c.opb_sel = opb;
        c.mem_rd  = 1'b0;
        c.mem_wr  = 1'b0;
        c.reg_wr  = wr;
        c.reg_dst = dst;
        return c;
    endfunction

    always_comb begin
        ctrl_o = make_ctrl(ALU_UNKNOWN, OPA_ZERO, OPB_ZERO, 1'b0, '0);
        if (!stage_i.valid) begin
            ctrl_o = make_ctrl(ALU_NOP, OPA_ZERO, OPB_ZERO, 1'b0, '0);
        end else begin
            case (inst.r_fields.opcode)
                OP_SPECIAL: begin
                    case (inst.r_fields.funct)
                        F_ADD, F_ADDU: begin
                            if (shamt_zero)
                                ctrl_o = make_ctrl(ALU_ADD, OPA_RS, OPB_RT, 1'b1, rd);
                        end
                        F_SUB, F_SUBU: begin
                            if (shamt_zero)
                                ctrl_o = make_ctrl(ALU_SUB, OPA_RS, OPB_RT, 1'b1, rd);
                        end
                        F_AND: begin
                            if (shamt_zero)
                                ctrl_o = make_ctrl(ALU_AND, OPA_RS, OPB_RT, 1'b1, rd);
                        end
                        F_OR: begin
                            if (shamt_zero)
                                ctrl_o = make_ctrl(ALU_OR, OPA_RS, OPB_RT, 1'b1, rd);
                        end
                        F_XOR: begin
                            if (shamt_zero)
                                ctrl_o = make_ctrl(ALU_XOR, OPA_RS, OPB_RT, 1'b1, rd);
                        end
                        F_SLT: begin
                            if (shamt_zero)
                                ctrl_o = make_ctrl(ALU_SLT, OPA_RS, OPB_RT, 1'b1, rd);
                        end
                        F_SLL: begin
                            if (rs_zero)
                                ctrl_o = make_ctrl(ALU_SLL, OPA_SHAMT, OPB_RT, 1'b1, rd);
                        end
                        F_SRL: begin
                            if (rs_zero)
                                ctrl_o = make_ctrl(ALU_SRL, OPA_SHAMT, OPB_RT, 1'b1, rd);
                        end
                        F_SRA: begin
                            if (rs_zero)
                                ctrl_o = make_ctrl(ALU_SRA, OPA_SHAMT, OPB_RT, 1'b1, rd);
                        end
                        F_JR: begin
                            if (rt_zero && rd_zero && shamt_zero)
                                ctrl_o = make_ctrl(ALU_JR, OPA_ZERO, OPB_ZERO, 1'b0, '0);
                        end
                        F_JALR: begin
                            if (rt_zero && shamt_zero)  // link to rd
                                ctrl_o = make_ctrl(ALU_JALR, OPA_PC, OPB_STEP, 1'b1, rd);
                        end
                        default: ;
                    endcase
                end
                OP_REGIMM: begin
                    if (rt == RT_BLTZ)
                        ctrl_o = make_ctrl(ALU_BLTZ, OPA_ZERO, OPB_ZERO, 1'b0, '0);
                    else if (rt == RT_BGEZAL)
                        ctrl_o = make_ctrl(ALU_BGEZAL, OPA_PC, OPB_STEP, 1'b1, REG_LINK);
                end
                OP_J:     ctrl_o = make_ctrl(ALU_J, OPA_ZERO, OPB_ZERO, 1'b0, '0);
                OP_JAL:   ctrl_o = make_ctrl(ALU_JAL, OPA_PC, OPB_STEP, 1'b1, REG_LINK);
                OP_BEQ:   ctrl_o = make_ctrl(ALU_BEQ, OPA_ZERO, OPB_ZERO, 1'b0, '0);
                OP_BNE:   ctrl_o = make_ctrl(ALU_BNE, OPA_ZERO, OPB_ZERO, 1'b0, '0);
                OP_BLEZ: begin
                    if (rt_zero)
                        ctrl_o = make_ctrl(ALU_BLEZ, OPA_ZERO, OPB_ZERO, 1'b0, '0);
                end
                OP_BGTZ: begin
                    if (rt_zero)
                        ctrl_o = make_ctrl(ALU_BGTZ, OPA_ZERO, OPB_ZERO, 1'b0, '0);
                end
                OP_ADDI,
                OP_ADDIU: ctrl_o = make_ctrl(ALU_ADD, OPA_RS, OPB_IMM_S, 1'b1, rt);
                OP_SLTI:  ctrl_o = make_ctrl(ALU_SLT, OPA_RS, OPB_IMM_S, 1'b1, rt);
                OP_SLTIU: ctrl_o = make_ctrl(ALU_SLTU, OPA_RS, OPB_IMM_S, 1'b1, rt);
                OP_ANDI:  ctrl_o = make_ctrl(ALU_AND, OPA_RS, OPB_IMM_Z, 1'b1, rt);
                OP_ORI:   ctrl_o = make_ctrl(ALU_OR, OPA_RS, OPB_IMM_Z, 1'b1, rt);
                OP_XORI:  ctrl_o = make_ctrl(ALU_XOR, OPA_RS, OPB_IMM_Z, 1'b1, rt);
                OP_LUI: begin
                    if (rs_zero)
                        ctrl_o = make_ctrl(ALU_LUI, OPA_LUI, OPB_ZERO, 1'b1, rt);
                end
                OP_LW: begin
                    ctrl_o        = make_ctrl(ALU_LW, OPA_RS, OPB_IMM_S, 1'b1, rt);
                    ctrl_o.mem_rd = 1'b1;
                end
                OP_SW: begin
                    ctrl_o        = make_ctrl(ALU_SW, OPA_RS, OPB_IMM_S, 1'b0, '0);
                    ctrl_o.mem_wr = 1'b1;  // address = rs + imm, data = rt
                end
                default: ;  // dropped and illegal opcodes
            endcase
        end
    end

endmodule

`default_nettype wire

//--- source/operand_mux.sv
// purely combinational; operands settle within the cycle after the register file answers
`timescale 1ns/1ps
`default_nettype none

module operand_mux
    import idu_pkg::*;
(
    input  fetch_t stage_i,
    input  ctrl_t  ctrl_i,
    input  word_t  rs_data_i,
    input  word_t  rt_data_i,
    output word_t  op_a_o,
    output word_t  op_b_o,
    output word_t  store_data_o
);

    mips_inst_u inst;
    word_t      imm_s;
    word_t      imm_z;
    word_t      imm_hi;
    word_t      shamt_z;

    assign inst    = stage_i.inst;
    assign imm_s   = {{16{inst.i_fields.imm[15]}}, inst.i_fields.imm};
    assign imm_z   = {16'd0, inst.i_fields.imm};
    assign imm_hi  = {inst.i_fields.imm, 16'd0};  // lui
    assign shamt_z = {27'd0, inst.r_fields.shamt};

    always_comb begin
        case (ctrl_i.opa_sel)
            OPA_RS:    op_a_o = rs_data_i;
            OPA_SHAMT: op_a_o = shamt_z;
            OPA_LUI:   op_a_o = imm_hi;
            OPA_PC:    op_a_o = stage_i.pc;  // link base, latched pc
            default:   op_a_o = '0;
        endcase
    end

    always_comb begin
        case (ctrl_i.opb_sel)
            OPB_RT:    op_b_o = rt_data_i;
            OPB_IMM_S: op_b_o = imm_s;
            OPB_IMM_Z: op_b_o = imm_z;
            OPB_STEP:  op_b_o = PC_STEP;
            default:   op_b_o = '0;
        endcase
    end

    assign store_data_o = rt_data_i;

endmodule

`default_nettype wire

//--- source/branch_unit.sv
// no delay-slot handling here; branch target is formed even when the branch is not taken
`timescale 1ns/1ps
`default_nettype none

module branch_unit
    import idu_pkg::*;
(
    input  fetch_t  stage_i,
    input  alu_op_e alu_op_i,
    input  word_t   rs_data_i,
    input  word_t   rt_data_i,
    output jump_t   jump_o
);

    mips_inst_u inst;
    word_t      pc_plus4;
    word_t      br_target;
    word_t      jmp_target;
    logic       rs_neg;
    logic       rs_zero;

    assign inst       = stage_i.inst;
    assign pc_plus4   = stage_i.pc + PC_STEP;
    assign br_target  = pc_plus4 + {{14{inst.i_fields.imm[15]}}, inst.i_fields.imm, 2'b00};
    assign jmp_target = {pc_plus4[31:28], inst.j_fields.index, 2'b00};  // same 256M region
    assign rs_neg     = rs_data_i[31];
    assign rs_zero    = (rs_data_i == '0);

    always_comb begin
        jump_o = '0;
        case (alu_op_i)
            ALU_BEQ: begin
                jump_o.taken  = (rs_data_i == rt_data_i);
                jump_o.target = br_target;
            end
            ALU_BNE: begin
                jump_o.taken  = (rs_data_i != rt_data_i);
                jump_o.target = br_target;
            end
            ALU_BLEZ: begin
                jump_o.taken  = rs_neg || rs_zero;
                jump_o.target = br_target;
            end
            ALU_BGTZ: begin
                jump_o.taken  = !rs_neg && !rs_zero;  // strictly positive
                jump_o.target = br_target;
            end
            ALU_BLTZ: begin
                jump_o.taken  = rs_neg;
                jump_o.target = br_target;
            end
            ALU_BGEZAL: begin
                jump_o.taken  = !rs_neg;
                jump_o.target = br_target;
            end
            ALU_J, ALU_JAL: begin
                jump_o.taken  = 1'b1;
                jump_o.target = jmp_target;
            end
            ALU_JR, ALU_JALR: begin
                jump_o.taken  = 1'b1;
                jump_o.target = rs_data_i;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

//--- source/idu_top.sv
// decode stage with one cycle latency; register file is external and must answer combinationally
`timescale 1ns/1ps
`default_nettype none

module idu_top
    import idu_pkg::*;
(
    input  wire       clk,
    input  wire       rst,
    input  word_t     pc_i,
    input  word_t     inst_i,
    input  word_t     rs_data_i,
    input  word_t     rt_data_i,
    output reg_addr_t rs_addr_o,
    output reg_addr_t rt_addr_o,
    output ctrl_t     ctrl_o,
    output word_t     op_a_o,
    output word_t     op_b_o,
    output word_t     store_data_o,
    output jump_t     jump_o
);

    fetch_t stage;
    ctrl_t  ctrl;

    fetch_latch u_fetch_latch (
        .clk       (clk),
        .rst       (rst),
        .pc_i      (pc_i),
        .inst_i    (inst_i),
        .stage_o   (stage),
        .rs_addr_o (rs_addr_o),
        .rt_addr_o (rt_addr_o)
    );

    inst_decoder u_inst_decoder (
        .stage_i (stage),
        .ctrl_o  (ctrl)
    );

    operand_mux u_operand_mux (
        .stage_i      (stage),
        .ctrl_i       (ctrl),
        .rs_data_i    (rs_data_i),
        .rt_data_i    (rt_data_i),
        .op_a_o       (op_a_o),
        .op_b_o       (op_b_o),
        .store_data_o (store_data_o)
    );

    branch_unit u_branch_unit (
        .stage_i   (stage),
        .alu_op_i  (ctrl.alu_op),
        .rs_data_i (rs_data_i),
        .rt_data_i (rt_data_i),
        .jump_o    (jump_o)
    );

    assign ctrl_o = ctrl;  // to execute stage

endmodule

`default_nettype wire

//--- tb/tb_clock.sv
// free-running 40 ns clock; synchronous reset held high for the first 3 rising edges
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
    output logic clk_o,
    output logic rst_o
);

    initial begin
        clk_o = 1'b0;
        forever #20 clk_o = ~clk_o;
    end

    initial begin
        rst_o = 1'b1;
        repeat (3) @(posedge clk_o);
        @(negedge clk_o);
        rst_o = 1'b0;  // released away from the sampling edge
    end

endmodule

`default_nettype wire

//--- tb/idu_tb.sv
// directed tests for idu_top; register file modeled here and answers combinationally
`timescale 1ns/1ps
`default_nettype none

module idu_tb
    import idu_pkg::*;
;

    wire       clk;
    wire       rst;
    word_t     pc_i;
    word_t     inst_i;
    word_t     rs_data;
    word_t     rt_data;
    reg_addr_t rs_addr;
    reg_addr_t rt_addr;
    ctrl_t     ctrl;
    word_t     op_a;
    word_t     op_b;
    word_t     store_data;
    jump_t     jump;

    word_t       regs [32];
    logic [31:0] seed = 32'h660;
    int          errors = 0;
    int          cycles = 0;
    localparam int MAX_CYCLES = 2000;

    tb_clock u_clock (.clk_o(clk), .rst_o(rst));

    idu_top dut (
        .clk(clk), .rst(rst), .pc_i(pc_i), .inst_i(inst_i),
        .rs_data_i(rs_data), .rt_data_i(rt_data),
        .rs_addr_o(rs_addr), .rt_addr_o(rt_addr), .ctrl_o(ctrl),
        .op_a_o(op_a), .op_b_o(op_b), .store_data_o(store_data), .jump_o(jump)
    );

    assign rs_data = regs[rs_addr];  // register file read
    assign rt_data = regs[rt_addr];

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("TEST FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic reg_addr_t rand_reg();
        logic [31:0] r;
        r = next_rand();
        return r[20:16];
    endfunction

    function automatic ctrl_t build_ctrl(input alu_op_e op, input opa_sel_e a,
                                         input opb_sel_e b, input logic rd,
                                         input logic wr, input logic we, input reg_addr_t dst);
        ctrl_t c;
        c.alu_op  = op;
        c.opa_sel = a;
        c.opb_sel = b;
        c.mem_rd  = rd;
        c.mem_wr  = wr;
        c.reg_wr  = we;
        c.reg_dst = dst;
        return c;
    endfunction

    task automatic check_ctrl(input string name, input ctrl_t exp, input ctrl_t act);
        if (exp !== act) begin
            errors++;
            $display("ERR %0t %s exp=%h act=%h", $time, name, exp, act);
        end
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (exp !== act) begin
            errors++;
            $display("ERR %0t %s exp=%h act=%h", $time, name, exp, act);
        end
    endtask

    task automatic check_addr(input string name, input reg_addr_t exp, input reg_addr_t act);
        if (exp !== act) begin
            errors++;
            $display("ERR %0t %s exp=%h act=%h", $time, name, exp, act);
        end
    endtask

    task automatic check_jump(input string name, input jump_t exp, input jump_t act);
        if (exp !== act) begin
            errors++;
            $display("ERR %0t %s exp=%h act=%h", $time, name, exp, act);
        end
    endtask

    // one instruction through the stage with every output checked a cycle later
    task automatic issue(input word_t pc, input word_t inst, input ctrl_t ec,
                         input word_t ea, input word_t eb, input jump_t ej);
        @(negedge clk);
        pc_i   = pc;
        inst_i = inst;
        @(posedge clk);
        #5;
        check_addr("rs_addr_o", inst[25:21], rs_addr);
        check_addr("rt_addr_o", inst[20:16], rt_addr);
        check_ctrl("ctrl_o", ec, ctrl);
        check_word("op_a_o", ea, op_a);
        check_word("op_b_o", eb, op_b);
        check_word("store_data_o", regs[inst[20:16]], store_data);
        check_jump("jump_o", ej, jump);
    endtask

    task automatic check_bubble();
        check_ctrl("ctrl_o", build_ctrl(ALU_NOP, OPA_ZERO, OPB_ZERO, 0, 0, 0, 5'd0), ctrl);
        check_jump("jump_o", '0, jump);
        check_word("op_a_o", '0, op_a);
        check_word("op_b_o", '0, op_b);
    endtask

    task automatic test_reset();
        @(posedge clk);
        #5;
        check_bubble();
        wait (!rst);
        #1;
        check_bubble();  // first cycle after release
    endtask

    task automatic do_rtype(input logic [5:0] funct, input alu_op_e alu, input logic shift);
        reg_addr_t  rs;
        reg_addr_t  rt;
        reg_addr_t  rd;
        logic [4:0] sh;
        word_t      ea;
        rs = shift ? 5'd0 : rand_reg();
        rt = rand_reg();
        rd = rand_reg();
        sh = shift ? rand_reg() : 5'd0;
        ea = shift ? {27'd0, sh} : regs[rs];
        issue(next_rand(), {6'd0, rs, rt, rd, sh, funct},
              build_ctrl(alu, shift ? OPA_SHAMT : OPA_RS, OPB_RT, 0, 0, 1, rd),
              ea, regs[rt], '0);
    endtask

    // kind 0 sign-extended, 1 zero-extended, 2 lui, 3 lw, 4 sw
    task automatic do_itype(input logic [5:0] op, input alu_op_e alu, input int kind);
        reg_addr_t   rs;
        reg_addr_t   rt;
        logic [15:0] imm;
        logic [31:0] r;
        ctrl_t       ec;
        word_t       ea;
        word_t       eb;
        r   = next_rand();
        imm = r[15:0];
        rs  = (kind == 2) ? 5'd0 : rand_reg();
        rt  = rand_reg();
        ea  = regs[rs];
        eb  = {{16{imm[15]}}, imm};
        case (kind)
            1: begin
                ec = build_ctrl(alu, OPA_RS, OPB_IMM_Z, 0, 0, 1, rt);
                eb = {16'd0, imm};
            end
            2: begin
                ec = build_ctrl(ALU_LUI, OPA_LUI, OPB_ZERO, 0, 0, 1, rt);
                ea = {imm, 16'd0};
                eb = '0;
            end
            3: ec = build_ctrl(ALU_LW, OPA_RS, OPB_IMM_S, 1, 0, 1, rt);
            4: ec = build_ctrl(ALU_SW, OPA_RS, OPB_IMM_S, 0, 1, 0, 5'd0);
            default: ec = build_ctrl(alu, OPA_RS, OPB_IMM_S, 0, 0, 1, rt);
        endcase
        issue(next_rand(), {op, rs, rt, imm}, ec, ea, eb, '0);
    endtask

    task automatic do_branch(input logic [5:0] op, input reg_addr_t code, input alu_op_e alu,
                             input word_t rs_val, input word_t rt_val, input logic taken);
        logic [31:0] r;
        reg_addr_t   rs;
        reg_addr_t   rt;
        word_t       pc;
        jump_t       ej;
        ctrl_t       ec;
        r  = next_rand();
        rs = {1'b0, r[3:0]} | 5'd1;
        rt = (op == OP_BEQ || op == OP_BNE) ? {1'b1, r[7:4]} : code;
        pc = {r[31:2], 2'b00};
        regs[rs] = rs_val;
        if (op == OP_BEQ || op == OP_BNE)
            regs[rt] = rt_val;
        ej.taken  = taken;
        ej.target = pc + 32'd4 + {{14{r[31]}}, r[31:16], 2'b00};
        ec = build_ctrl(alu, OPA_ZERO, OPB_ZERO, 0, 0, 0, 5'd0);
        if (alu == ALU_BGEZAL) begin
            ec = build_ctrl(alu, OPA_PC, OPB_STEP, 0, 0, 1, REG_LINK);
            issue(pc, {op, rs, rt, r[31:16]}, ec, pc, 32'd4, ej);
        end else begin
            issue(pc, {op, rs, rt, r[31:16]}, ec, '0, '0, ej);
        end
    endtask

    task automatic do_jump(input alu_op_e alu);
        logic [31:0] r;
        reg_addr_t   rs;
        reg_addr_t   rd;
        word_t       pc;
        word_t       pc4;
        jump_t       ej;
        r   = next_rand();
        rs  = rand_reg();
        rd  = rand_reg();
        pc  = (next_rand() | 32'h0fff_ffff) ^ 32'h3;  // last word of a 256M region
        pc4 = pc + 32'd4;
        ej.taken = 1'b1;
        case (alu)
            ALU_J: begin
                ej.target = {pc4[31:28], r[25:0], 2'b00};
                issue(pc, {OP_J, r[25:0]}, build_ctrl(alu, OPA_ZERO, OPB_ZERO, 0, 0, 0, 5'd0),
                      '0, '0, ej);
            end
            ALU_JAL: begin
                ej.target = {pc4[31:28], r[25:0], 2'b00};
                issue(pc, {OP_JAL, r[25:0]}, build_ctrl(alu, OPA_PC, OPB_STEP, 0, 0, 1, REG_LINK),
                      pc, 32'd4, ej);
            end
            ALU_JR: begin
                ej.target = regs[rs];
                issue(pc, {6'd0, rs, 15'd0, F_JR},
                      build_ctrl(alu, OPA_ZERO, OPB_ZERO, 0, 0, 0, 5'd0), '0, '0, ej);
            end
            default: begin
                ej.target = regs[rs];
                issue(pc, {6'd0, rs, 5'd0, rd, 5'd0, F_JALR},
                      build_ctrl(ALU_JALR, OPA_PC, OPB_STEP, 0, 0, 1, rd), pc, 32'd4, ej);
            end
        endcase
    endtask

    task automatic test_rtype();
        repeat (4) begin
            do_rtype(F_ADD, ALU_ADD, 0);
            do_rtype(F_ADDU, ALU_ADD, 0);
            do_rtype(F_SUB, ALU_SUB, 0);
            do_rtype(F_SUBU, ALU_SUB, 0);
            do_rtype(F_AND, ALU_AND, 0);
            do_rtype(F_OR, ALU_OR, 0);
            do_rtype(F_XOR, ALU_XOR, 0);
            do_rtype(F_SLT, ALU_SLT, 0);
            do_rtype(F_SLL, ALU_SLL, 1);
            do_rtype(F_SRL, ALU_SRL, 1);
            do_rtype(F_SRA, ALU_SRA, 1);
        end
    endtask

    task automatic test_itype();
        repeat (4) begin
            do_itype(OP_ADDI, ALU_ADD, 0);
            do_itype(OP_ADDIU, ALU_ADD, 0);
            do_itype(OP_SLTI, ALU_SLT, 0);
            do_itype(OP_SLTIU, ALU_SLTU, 0);
            do_itype(OP_ANDI, ALU_AND, 1);
            do_itype(OP_ORI, ALU_OR, 1);
            do_itype(OP_XORI, ALU_XOR, 1);
            do_itype(OP_LUI, ALU_LUI, 2);
            do_itype(OP_LW, ALU_LW, 3);
            do_itype(OP_SW, ALU_SW, 4);
        end
    endtask

    task automatic test_branches();
        do_branch(OP_BEQ, 5'd0, ALU_BEQ, 32'h1234, 32'h1234, 1);
        do_branch(OP_BEQ, 5'd0, ALU_BEQ, 32'h1234, 32'h1235, 0);
        do_branch(OP_BNE, 5'd0, ALU_BNE, 32'h55, 32'h55, 0);
        do_branch(OP_BNE, 5'd0, ALU_BNE, 32'h55, 32'h8000_0055, 1);
        do_branch(OP_BLEZ, 5'd0, ALU_BLEZ, 32'd0, '0, 1);
        do_branch(OP_BLEZ, 5'd0, ALU_BLEZ, 32'hffff_fff0, '0, 1);
        do_branch(OP_BLEZ, 5'd0, ALU_BLEZ, 32'd7, '0, 0);
        do_branch(OP_BGTZ, 5'd0, ALU_BGTZ, 32'd0, '0, 0);
        do_branch(OP_BGTZ, 5'd0, ALU_BGTZ, 32'd9, '0, 1);
        do_branch(OP_BGTZ, 5'd0, ALU_BGTZ, 32'h8000_0000, '0, 0);
        do_branch(OP_REGIMM, RT_BLTZ, ALU_BLTZ, 32'hffff_ffff, '0, 1);
        do_branch(OP_REGIMM, RT_BLTZ, ALU_BLTZ, 32'd0, '0, 0);
        do_branch(OP_REGIMM, RT_BGEZAL, ALU_BGEZAL, 32'd0, '0, 1);
        do_branch(OP_REGIMM, RT_BGEZAL, ALU_BGEZAL, 32'h8000_0001, '0, 0);
        do_branch(OP_REGIMM, RT_BGEZAL, ALU_BGEZAL, 32'h7fff_ffff, '0, 1);
    endtask

    task automatic test_jumps();
        repeat (2) begin
            do_jump(ALU_J);
            do_jump(ALU_JAL);
            do_jump(ALU_JR);
            do_jump(ALU_JALR);
        end
    endtask

    task automatic test_unknown();
        logic [31:0] r;
        ctrl_t       ec;
        ec = build_ctrl(ALU_UNKNOWN, OPA_ZERO, OPB_ZERO, 0, 0, 0, 5'd0);
        issue(32'h100, {6'd0, rand_reg(), rand_reg(), 10'd0, 6'b011000}, ec, '0, '0, '0);  // mult
        issue(32'h104, 32'h0000_000c, ec, '0, '0, '0);  // syscall
        issue(32'h108, {6'b100000, rand_reg(), rand_reg(), 16'h0010}, ec, '0, '0, '0);  // lb
        repeat (60) begin
            r = next_rand();
            case (r[1:0])
                2'd0: do_rtype(F_ADD, ALU_ADD, 0);
                2'd1: do_rtype(F_SRA, ALU_SRA, 1);
                2'd2: do_itype(OP_ORI, ALU_OR, 1);
                default: do_itype(OP_LW, ALU_LW, 3);
            endcase
        end
    endtask

    initial begin
        pc_i   = '0;
        inst_i = '0;
        for (int i = 0; i < 32; i++)
            regs[i] = next_rand();
        test_reset();
        test_rtype();
        test_itype();
        test_branches();
        test_jumps();
        test_unknown();
        $display("errors: %0d after %0d cycles", errors, cycles);
        if (errors == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- src.f
source/idu_pkg.sv
source/fetch_latch.sv
source/inst_decoder.sv
source/operand_mux.sv
source/branch_unit.sv
source/idu_top.sv
tb/tb_clock.sv
tb/idu_tb.sv

//--- run.sh
#!/bin/sh
# build and run the decode-stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -f src.f --top-module idu_tb -o idu_sim; then
    echo "build failed"
    exit 1
fi

if ! ./obj_dir/idu_sim > sim.log 2>&1; then
    cat sim.log
    echo "simulation exited with an error"
    exit 1
fi

cat sim.log

if grep -q "TEST FAILED" sim.log; then
    exit 1
fi

if ! grep -q "TEST PASSED" sim.log; then
    echo "no result found in sim.log"
    exit 1
fi

exit 0
